// ==== src/cpuTypesPkg.sv ====
/*
  CPU types package
  Word and field types, opcode and ALU encodings, decoder control struct
*/
`default_nettype none

package cpuTypesPkg;

  localparam int WORD_WIDTH = 32;
  localparam int REG_COUNT  = 32;

  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [4:0]            regIdx_t;

  localparam word_t RESET_PC = '0; // First fetch address

  // Primary opcodes in bits 31:26
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDI  = 6'b001000,
    ADDIU = 6'b001001,
    SLTI  = 6'b001010,
    SLTIU = 6'b001011,
    ANDI  = 6'b001100,
    ORI   = 6'b001101,
    XORI  = 6'b001110,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  // R-type function codes in bits 5:0
  typedef enum logic [5:0] {
    SLL  = 6'b000000,
    SRL  = 6'b000010,
    JR   = 6'b001000,
    ADD  = 6'b100000,
    ADDU = 6'b100001,
    SUB  = 6'b100010,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    XOR  = 6'b100110,
    NOR  = 6'b100111,
    SLT  = 6'b101010,
    SLTU = 6'b101011
  } funct_t;

  typedef enum logic [3:0] {
    ALU_SLL  = 4'd0,
    ALU_SRL  = 4'd1,
    ALU_ADD  = 4'd2,
    ALU_SUB  = 4'd3,
    ALU_AND  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_NOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } aluOp_t;

  typedef struct packed {
    opcode_t    opcode;
    regIdx_t    rs;
    regIdx_t    rt;
    regIdx_t    rd;
    logic [4:0] shamt;
    funct_t     funct;
  } rType_t;

  typedef struct packed {
    opcode_t     opcode;
    regIdx_t     rs;
    regIdx_t     rt;
    logic [15:0] imm;
  } iType_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] addr; // Word target
  } jType_t;

  typedef struct packed {
    logic   regDst;   // Write rd instead of rt
    logic   regWen;
    logic   aluSrc;   // Immediate as operand B
    logic   memToReg;
    logic   dRen;
    logic   dWen;
    logic   branch;
    logic   bne;
    logic   jmp;
    logic   jl;       // Link into r31
    logic   jmpReg;
    logic   shiftSel; // rt as operand A
    logic   zeroExt;
    logic   lui;
    logic   halt;
    aluOp_t aluOp;
  } ctrl_t;

endpackage

`default_nettype wire

// ==== src/controlUnit.sv ====
/*
  Control unit
  Combinational decode of one instruction word into the control struct
*/
`timescale 1ns/10ps
`default_nettype none

module controlUnit import cpuTypesPkg::*; (
  input  word_t instr,
  output ctrl_t ctrl
);

  rType_t rFields;

  assign rFields = instr;

  always_comb begin
    ctrl = '0;

    if (rFields.opcode == RTYPE) begin
      ctrl.regDst = 1'b1;
      ctrl.regWen = 1'b1;
      ctrl.aluOp  = ALU_ADD;

      case (rFields.funct)
        SLL: begin
          ctrl.aluOp    = ALU_SLL;
          ctrl.shiftSel = 1'b1;
        end
        SRL: begin
          ctrl.aluOp    = ALU_SRL;
          ctrl.shiftSel = 1'b1;
        end
        JR: begin
          ctrl.regWen = 1'b0; // Nothing written back
          ctrl.jmpReg = 1'b1;
        end
        ADD, ADDU: begin
          ctrl.aluOp = ALU_ADD; // Same op because overflow is not trapped
        end
        SUB, SUBU: begin
          ctrl.aluOp = ALU_SUB;
        end
        AND: begin
          ctrl.aluOp = ALU_AND;
        end
        OR: begin
          ctrl.aluOp = ALU_OR;
        end
        XOR: begin
          ctrl.aluOp = ALU_XOR;
        end
        NOR: begin
          ctrl.aluOp = ALU_NOR;
        end
        SLT: begin
          ctrl.aluOp = ALU_SLT;
        end
        SLTU: begin
          ctrl.aluOp = ALU_SLTU;
        end
        default: begin
          ctrl.aluOp = ALU_ADD;
        end
      endcase
    end else begin
      // I and J type start out as ADDI
      ctrl.regWen = 1'b1;
      ctrl.aluSrc = 1'b1;
      ctrl.aluOp  = ALU_ADD;

      case (rFields.opcode)
        ANDI: begin
          ctrl.aluOp   = ALU_AND;
          ctrl.zeroExt = 1'b1;
        end
        ORI: begin
          ctrl.aluOp   = ALU_OR;
          ctrl.zeroExt = 1'b1;
        end
        XORI: begin
          ctrl.aluOp   = ALU_XOR;
          ctrl.zeroExt = 1'b1;
        end
        SLTI: begin
          ctrl.aluOp = ALU_SLT;
        end
        SLTIU: begin
          ctrl.aluOp = ALU_SLTU; // Sign-extended immediate compared unsigned
        end
        LUI: begin
          ctrl.lui = 1'b1;
        end
        LW: begin
          ctrl.memToReg = 1'b1;
          ctrl.dRen     = 1'b1;
        end
        SW: begin
          ctrl.regWen = 1'b0;
          ctrl.dWen   = 1'b1;
        end
        BEQ, BNE: begin
          ctrl.branch = 1'b1;
          ctrl.regWen = 1'b0;
          ctrl.aluSrc = 1'b0; // Compare rs against rt
          ctrl.aluOp  = ALU_SUB;
          ctrl.bne    = (rFields.opcode == BNE);
        end
        J: begin
          ctrl.regWen = 1'b0;
          ctrl.jmp    = 1'b1;
        end
        JAL: begin
          ctrl.jmp = 1'b1;
          ctrl.jl  = 1'b1;
        end
        HALT: begin
          ctrl.regWen = 1'b0;
          ctrl.halt   = 1'b1;
        end
        default: begin
          ctrl.aluOp = ALU_ADD; // ADDI, ADDIU and unknown opcodes
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/registerFile.sv ====
/*
  Register file
  32 words, two combinational reads, one write per clock, r0 tied to zero
*/
`timescale 1ns/10ps
`default_nettype none

module registerFile import cpuTypesPkg::*; (
  input  logic    CLK,
  input  logic    arstN,
  input  regIdx_t rsIdx,
  input  regIdx_t rtIdx,
  input  regIdx_t wIdx,
  input  logic    wen,
  input  word_t   wData,
  output word_t   rsData,
  output word_t   rtData
);

  word_t regs [REG_COUNT];

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      regs <= '{default: '0};
    end else if (wen && (wIdx != '0)) begin // r0 never written
      regs[wIdx] <= wData;
    end
  end

  // Combinational reads of the current contents
  assign rsData = (rsIdx == '0) ? '0 : regs[rsIdx];
  assign rtData = (rtIdx == '0) ? '0 : regs[rtIdx];

endmodule

`default_nettype wire

// ==== src/alu.sv ====
/*
  ALU
  Add, subtract, logic, set-less-than and logical shifts, with zero flag
*/
`timescale 1ns/10ps
`default_nettype none

module alu import cpuTypesPkg::*; (
  input  word_t      opA,
  input  word_t      opB,
  input  logic [4:0] shamt,
  input  aluOp_t     op,
  output word_t      result,
  output logic       zero
);

  always_comb begin
    case (op)
      ALU_SLL: begin
        result = opA << shamt;
      end
      ALU_SRL: begin
        result = opA >> shamt; // Logical shift with zero fill
      end
      ALU_ADD: begin
        result = opA + opB;
      end
      ALU_SUB: begin
        result = opA - opB;
      end
      ALU_AND: begin
        result = opA & opB;
      end
      ALU_OR: begin
        result = opA | opB;
      end
      ALU_XOR: begin
        result = opA ^ opB;
      end
      ALU_NOR: begin
        result = ~(opA | opB);
      end
      ALU_SLT: begin
        result = word_t'($signed(opA) < $signed(opB));
      end
      ALU_SLTU: begin
        result = word_t'(opA < opB);
      end
      default: begin
        result = '0;
      end
    endcase
  end

  assign zero = (result == '0); // Branch compare uses SUB

endmodule

`default_nettype wire

// ==== src/singleCycleCpu.sv ====
/*
  Single-cycle MIPS core
  PC, halt flag, immediate extension, write-back and next-PC selection
*/
`timescale 1ns/10ps
`default_nettype none

module singleCycleCpu import cpuTypesPkg::*; (
  input  logic  CLK,
  input  logic  arstN,
  input  word_t iData,
  input  word_t dRdata,
  output word_t iAddr,
  output word_t dAddr,
  output word_t dWdata,
  output logic  dRen,
  output logic  dWen,
  output logic  halt
);

  ctrl_t   ctrl;
  rType_t  rFields;
  iType_t  iFields;
  jType_t  jFields;

  word_t   pc;
  word_t   pcNext;
  word_t   pcPlus4;
  word_t   branchTarget;
  word_t   jumpTarget;
  word_t   immExt;
  word_t   rsData;
  word_t   rtData;
  word_t   aluA;
  word_t   aluB;
  word_t   aluResult;
  word_t   wData;
  regIdx_t wIdx;
  logic    aluZero;
  logic    branchTaken;
  logic    haltReg;

  // Field views of the fetched word
  assign rFields = iData;
  assign iFields = iData;
  assign jFields = iData;

  controlUnit u0 (
    .instr (iData),
    .ctrl  (ctrl)
  );

  assign immExt = ctrl.zeroExt ? {16'b0, iFields.imm} : {{16{iFields.imm[15]}}, iFields.imm};

  assign wIdx = ctrl.regDst ? rFields.rd :
                ctrl.jl     ? regIdx_t'(5'd31) :
                              iFields.rt;

  assign wData = ctrl.jl       ? pcPlus4 :
                 ctrl.lui      ? {iFields.imm, 16'b0} :
                 ctrl.memToReg ? dRdata :
                                 aluResult;

  registerFile u1 (
    .CLK    (CLK),
    .arstN  (arstN),
    .rsIdx  (iFields.rs),
    .rtIdx  (iFields.rt),
    .wIdx   (wIdx),
    .wen    (ctrl.regWen & ~haltReg),
    .wData  (wData),
    .rsData (rsData),
    .rtData (rtData)
  );

  assign aluA = ctrl.shiftSel ? rtData : rsData; // Shifts act on rt
  assign aluB = ctrl.aluSrc ? immExt : rtData;

  alu u2 (
    .opA    (aluA),
    .opB    (aluB),
    .shamt  (rFields.shamt),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  assign pcPlus4      = pc + 32'd4;
  assign branchTarget = pcPlus4 + {{14{iFields.imm[15]}}, iFields.imm, 2'b00};
  assign jumpTarget   = {pc[WORD_WIDTH-1 -: 4], jFields.addr, 2'b00};
  assign branchTaken  = ctrl.branch & (aluZero ^ ctrl.bne);

  always_comb begin
    if (haltReg || ctrl.halt) begin
      pcNext = pc; // Hold on the HALT word
    end else if (ctrl.jmpReg) begin
      pcNext = rsData;
    end else if (ctrl.jmp) begin
      pcNext = jumpTarget;
    end else if (branchTaken) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      pc      <= RESET_PC;
      haltReg <= 1'b0;
    end else begin
      pc <= pcNext;
      if (ctrl.halt) begin
        haltReg <= 1'b1; // Sticky until reset
      end
    end
  end

  assign iAddr  = pc;
  assign dAddr  = aluResult;
  assign dWdata = rtData;
  assign dRen   = ctrl.dRen;
  assign dWen   = ctrl.dWen & ~haltReg;
  assign halt   = haltReg;

endmodule

`default_nettype wire

// ==== verif/cpuTb.sv ====
/*
  Testbench for the single-cycle MIPS core
  Loads programs and expected stores from a trace, runs each test from reset,
  checks stores, the halt PC and that the core stays halted
*/
`timescale 1ns/10ps
`default_nettype none

module cpuTb import cpuTypesPkg::*; ();

  localparam int    CLK_PERIOD   = 4;
  localparam int    RESET_CYCLES = 10;
  localparam int    HOLD_CYCLES  = 8; // Cycles watched after halt
  localparam int    MEM_WORDS    = 256;
  localparam int    MAX_TESTS    = 16;
  localparam int    SEED         = 53905;
  localparam word_t HALT_WORD    = 32'hFC00_0000;
  localparam string TRACE_FILE   = "verif/cpuTrace.txt";
  localparam logic [5:0] LW_OPCODE = 6'b100011; // Load word primary opcode

  // One trace record tagged with its test
  typedef struct packed {
    int    test;
    word_t addr;
    word_t data;
  } rec_t;

  logic  CLK;
  logic  arstN;
  logic  dRen;
  logic  dWen;
  logic  halt;
  word_t iAddr;
  word_t iData;
  word_t dAddr;
  word_t dWdata;
  word_t dRdata;

  word_t iMem [MEM_WORDS];
  word_t dMem [MEM_WORDS];

  rec_t  progQ [$];
  rec_t  dataQ [$];
  rec_t  storeQ [$];
  string nameQ [$];
  word_t haltPcs [MAX_TESTS];
  int    errorCount;
  int    failedTests;
  int    watchCycles;

  singleCycleCpu dut0 (
    .CLK    (CLK),
    .arstN  (arstN),
    .iData  (iData),
    .dRdata (dRdata),
    .iAddr  (iAddr),
    .dAddr  (dAddr),
    .dWdata (dWdata),
    .dRen   (dRen),
    .dWen   (dWen),
    .halt   (halt)
  );

  // Both memories answer in the same cycle
  assign iData  = iMem[iAddr[9:2]];
  assign dRdata = dMem[dAddr[9:2]];

  always @(posedge CLK) begin
    if (arstN && dWen) begin
      dMem[dAddr[9:2]] <= dWdata;
    end
  end

  initial begin
    CLK = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) CLK = ~CLK;
    end
  end

  task automatic loadTrace();
    int    fd;
    int    c;
    int    n;
    int    t;
    byte   ch;
    word_t a;
    word_t d;
    word_t pc;
    string name;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open trace file %s", TRACE_FILE);
      errorCount++;
    end else begin
      t  = -1;
      pc = '0;
      c  = $fgetc(fd);
      while (c != -1) begin
        ch = byte'(c);
        case (ch)
          "#": begin
            while (c != -1 && c != 10) begin // Skip to end of line
              c = $fgetc(fd);
            end
          end
          "T": begin
            n = $fscanf(fd, " %s", name);
            nameQ.push_back(name);
            t++;
            pc = '0;
          end
          "P": begin
            n = $fscanf(fd, " %h", d);
            progQ.push_back(rec_t'{t, pc, d});
            pc = pc + 32'd4;
          end
          "D": begin
            n = $fscanf(fd, " %h %h", a, d);
            dataQ.push_back(rec_t'{t, a, d});
          end
          "S": begin
            n = $fscanf(fd, " %h %h", a, d);
            storeQ.push_back(rec_t'{t, a, d});
          end
          "H": begin
            n = $fscanf(fd, " %h", a);
            haltPcs[t] = a;
          end
          default: begin
          end
        endcase
        c = $fgetc(fd);
      end
      $fclose(fd);
    end
  endtask

  task automatic checkStore(input string name, input rec_t exp);
    if (dAddr !== exp.addr) begin
      $display("[FAIL] %s: dAddr expected 0x%08h, got 0x%08h", name, exp.addr, dAddr);
      errorCount++;
    end
    if (dWdata !== exp.data) begin
      $display("[FAIL] %s: dWdata expected 0x%08h, got 0x%08h", name, exp.data, dWdata);
      errorCount++;
    end
  endtask

  task automatic runTest(input int t);
    rec_t  expStores [$];
    int    seen;
    int    cycles;
    int    limit;
    int    errsBefore;
    int    i;
    logic  expRen;
    word_t haltPc;
    haltPc     = haltPcs[t];
    errsBefore = errorCount;
    seen       = 0;
    cycles     = 0;
    limit      = 0;
    arstN      = 1'b0;
    for (i = 0; i < MEM_WORDS; i++) begin
      iMem[i] = HALT_WORD; // Stray fetches stop the core
      dMem[i] = $urandom;
    end
    foreach (progQ[k]) begin
      if (progQ[k].test == t) begin
        iMem[progQ[k].addr[9:2]] = progQ[k].data;
        limit += 4;
      end
    end
    foreach (dataQ[k]) begin
      if (dataQ[k].test == t) begin
        dMem[dataQ[k].addr[9:2]] = dataQ[k].data;
      end
    end
    foreach (storeQ[k]) begin
      if (storeQ[k].test == t) begin
        expStores.push_back(storeQ[k]);
      end
    end
    repeat (RESET_CYCLES) @(negedge CLK);
    arstN = 1'b1;

    while (!halt && cycles < limit) begin
      expRen = (iData[31:26] == LW_OPCODE); // Only LW reads data memory
      if (dRen !== expRen) begin
        $display("[FAIL] %s: dRen expected 0x%0h, got 0x%0h", nameQ[t], expRen, dRen);
        errorCount++;
      end
      if (dWen) begin
        if (seen < expStores.size()) begin
          checkStore(nameQ[t], expStores[seen]);
        end else begin
          $display("%s: unexpected extra store to 0x%08h", nameQ[t], dAddr);
          errorCount++;
        end
        seen++;
      end
      @(negedge CLK);
      cycles++;
    end

    if (!halt) begin
      $display("%s: core did not halt within %0d cycles", nameQ[t], limit);
      errorCount++;
    end else begin
      if (iAddr !== haltPc) begin
        $display("[FAIL] %s: iAddr expected 0x%08h, got 0x%08h", nameQ[t], haltPc, iAddr);
        errorCount++;
      end
      repeat (HOLD_CYCLES) begin
        @(negedge CLK);
        if (!halt) begin
          $display("%s: halt dropped while the core should stay stopped", nameQ[t]);
          errorCount++;
        end
        if (dWen) begin
          $display("%s: store issued after halt", nameQ[t]);
          errorCount++;
        end
        if (dRen) begin
          $display("%s: load issued after halt", nameQ[t]);
          errorCount++;
        end
        if (iAddr !== haltPc) begin
          $display("[FAIL] %s: iAddr expected 0x%08h, got 0x%08h", nameQ[t], haltPc, iAddr);
          errorCount++;
        end
      end
    end
    if (seen < expStores.size()) begin
      $display("%s: only %0d of %0d expected stores seen", nameQ[t], seen, expStores.size());
      errorCount++;
    end

    if (errorCount == errsBefore) begin
      $display("PASS %s: %0d stores, halted at 0x%08h", nameQ[t], seen, haltPc);
    end else begin
      failedTests++;
      $display("FAIL %s: %0d errors", nameQ[t], errorCount - errsBefore);
    end
  endtask

  // Watchdog armed once the trace length is known
  initial begin
    wait (watchCycles > 0);
    repeat (watchCycles) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, run stopped", watchCycles);
    $display("Test failed");
    $finish;
  end

  initial begin : mainSeq
    int seedDummy;
    int t;
    int i;
    seedDummy   = $urandom(SEED);
    arstN       = 1'b0;
    errorCount  = 0;
    failedTests = 0;
    for (i = 0; i < MEM_WORDS; i++) begin
      iMem[i] = HALT_WORD;
      dMem[i] = '0;
    end
    loadTrace();
    watchCycles = progQ.size() * 4 + nameQ.size() * (RESET_CYCLES + HOLD_CYCLES + 2) + 100;
    @(negedge CLK);
    for (t = 0; t < nameQ.size(); t++) begin
      runTest(t);
    end
    $display("Summary: %0d tests run, %0d failed, %0d errors",
             nameQ.size(), failedTests, errorCount);
    if (errorCount == 0 && nameQ.size() > 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/cpuTrace.txt ====
# T name | P instr word | D addr data (initial data) | S addr data (expected store) | H halt pc
# All values hex, program words are placed from address 0 in each test
T regAlu
P 2001FFFB  # addi r1, r0, -5
P 3C021234  # lui  r2, 0x1234
P 34425678  # ori  r2, r2, 0x5678
P 00221820  # add  r3, r1, r2
P AC030100
P 00221822  # sub
P AC030104
P 00221824  # and
P AC030108
P 00221825  # or
P AC03010C
P 00221826  # xor
P AC030110
P 00221827  # nor
P AC030114
P 0022182A  # slt
P AC030118
P 0022182B  # sltu
P AC03011C
P FC000000
S 00000100 12345673
S 00000104 EDCBA983
S 00000108 12345678
S 0000010C FFFFFFFB
S 00000110 EDCBA983
S 00000114 00000004
S 00000118 00000001
S 0000011C 00000000
H 0000004C
T immediate
P 20048000  # addi r4, r0, 0x8000
P AC040100
P 2805FFFF  # slti r5, r0, -1
P AC050104
P 34068001  # ori  r6, r0, 0x8001
P AC060108
P 3887FFFF  # xori r7, r4, 0xffff
P AC07010C
P 3088F0F0  # andi r8, r4, 0xf0f0
P AC080110
P 3C09ABCD  # lui  r9, 0xabcd
P AC090114
P 00095100  # sll  r10, r9, 4
P AC0A0118
P 00095202  # srl  r10, r9, 8
P AC0A011C
P FC000000
S 00000100 FFFF8000
S 00000104 00000000
S 00000108 00008001
S 0000010C FFFF7FFF
S 00000110 00008000
S 00000114 ABCD0000
S 00000118 BCD00000
S 0000011C 00ABCD00
H 00000040
T loadStore
D 00000200 CAFEF00D
P 8C010200  # lw   r1, 0x200(r0)
P AC010100
P 20000055  # addi r0, r0, 0x55
P AC000104
P 200201F0  # addi r2, r0, 0x1f0
P 8C430010  # lw   r3, 0x10(r2)
P AC030108
P FC000000
S 00000100 CAFEF00D
S 00000104 00000000
S 00000108 CAFEF00D
H 0000001C
T branches
P 20010007  # addi r1, r0, 7
P 20020007  # addi r2, r0, 7
P 20030009  # addi r3, r0, 9
P 10220001  # beq  r1, r2 taken
P AC030100
P 10230001  # beq  r1, r3 not taken
P AC010104
P 14230001  # bne  r1, r3 taken
P AC030108
P 14220001  # bne  r1, r2 not taken
P AC03010C
P FC000000
S 00000104 00000007
S 0000010C 00000009
H 0000002C
T jumps
P 08000002  # j    0x08
P AC000100
P 0C000006  # jal  0x18
P AC1F0104
P AC050108
P FC000000
P 20050077  # addi r5, r0, 0x77
P 03E00008  # jr   r31
P AC00010C
S 00000104 0000000C
S 00000108 00000077
H 00000014
T halt
P 20010011  # addi r1, r0, 0x11
P AC010100
P FC000000
P AC010104  # never reached
S 00000100 00000011
H 00000008

// ==== build.f ====
src/cpuTypesPkg.sv
src/controlUnit.sv
src/registerFile.sv
src/alu.sv
src/singleCycleCpu.sv
verif/cpuTb.sv

// ==== Makefile ====
# Verilator build and run for the single-cycle MIPS core

VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= cpuTb
RTL_TOP   ?= singleCycleCpu
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

RTL_SRCS := $(shell grep '^src/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
